// File: common/axi_wr_pkg.sv
// ----------------------------------------------------------------------
// Shared widths, channel structs and sizing constants for the
// buffered AXI4 write path
// ----------------------------------------------------------------------

package axi_wr_pkg;

    // AXI4 field widths
    typedef logic [3:0]  axi_id_t;
    typedef logic [15:0] axi_addr_t;
    typedef logic [7:0]  axi_len_t;
    typedef logic [31:0] axi_data_t;
    typedef logic [3:0]  axi_strb_t;
    typedef logic [1:0]  axi_resp_t;

    // Write data FIFO sizing
    localparam int FIFO_DEPTH = 16;
    localparam int FIFO_AW = 4;

    // Word RAM behind the buffer
    localparam int RAM_WORDS = 256;

    // B channel response codes
    localparam axi_resp_t RESP_OKAY = 2'd0;
    localparam axi_resp_t RESP_SLVERR = 2'd2;

    // Extra MSB tells full from empty
    typedef logic [FIFO_AW:0] fifo_ptr_t;
    typedef logic [7:0]       ram_addr_t;

    // AW channel payload
    typedef struct packed {
        axi_id_t    id;
        axi_addr_t  addr;
        axi_len_t   len;
        logic [2:0] size;
    } aw_beat_t;

    // W channel payload
    typedef struct packed {
        axi_data_t data;
        axi_strb_t strb;
        logic      last;
    } w_beat_t;

    // B channel payload
    typedef struct packed {
        axi_id_t   id;
        axi_resp_t resp;
    } b_beat_t;

endpackage

// File: flist.f
common/axi_wr_pkg.sv
hw/axi_fifo_wr/axi_aw_hold.sv
hw/axi_fifo_wr/axi_w_fifo.sv
hw/axi_ram_wr.sv
hw/axi_wr_buffer_top.sv
verif/tb_clk_gen.sv
verif/axi_wr_buffer_tb.sv

// File: hw/axi_fifo_wr/axi_aw_hold.sv
// ----------------------------------------------------------------------
// Write address hold FSM
// Keeps each AW beat back until its burst sits in the data FIFO
// or the FIFO has filled
// ----------------------------------------------------------------------

`timescale 1ns/1ps

module axi_aw_hold (
    input  logic                 clk,
    input  logic                 rst,
    input  axi_wr_pkg::aw_beat_t s_aw,
    input  logic                 s_awvalid,
    output logic                 s_awready,
    input  logic                 s_wvalid,
    input  logic                 s_wready,
    output logic                 hold,
    output axi_wr_pkg::aw_beat_t m_aw,
    output logic                 m_awvalid,
    input  logic                 m_awready
);

    typedef enum logic [1:0] {
        IDLE,
        TRANSFER_IN,
        TRANSFER_OUT
    } state_t;

    state_t     state;
    state_t     state_next;
    logic       hold_next;
    logic       s_awready_next;
    logic       m_awvalid_next;
    logic [8:0] count;
    logic [8:0] count_next;
    logic       aw_take;
    logic       w_take;
    logic       burst_done;

    assign aw_take    = s_awvalid && s_awready;
    assign w_take     = s_wvalid && s_wready;
    assign burst_done = count == {1'b0, m_aw.len};

    always_comb begin
        state_next     = state;
        hold_next      = hold;
        count_next     = count;
        s_awready_next = 1'b0;
        m_awvalid_next = m_awvalid && !m_awready;

        case (state)
            IDLE: begin
                // Open up once the previous address has gone out
                s_awready_next = !m_awvalid_next;
                hold_next      = 1'b1;
                if (aw_take) begin
                    s_awready_next = 1'b0;
                    hold_next      = 1'b0;
                    count_next     = '0;
                    state_next     = TRANSFER_IN;
                end
            end
            TRANSFER_IN: begin
                if (w_take) begin
                    count_next = count + 9'd1;
                    if (burst_done) begin
                        // Whole burst buffered
                        m_awvalid_next = 1'b1;
                        hold_next      = 1'b1;
                        state_next     = IDLE;
                    end else if (count_next == 9'(axi_wr_pkg::FIFO_DEPTH)) begin
                        // FIFO full, let the slave start draining
                        m_awvalid_next = 1'b1;
                        state_next     = TRANSFER_OUT;
                    end
                end
            end
            TRANSFER_OUT: begin
                // Address already released, count the rest of the burst
                if (w_take) begin
                    count_next = count + 9'd1;
                    if (burst_done) begin
                        hold_next  = 1'b1;
                        state_next = IDLE;
                    end
                end
            end
            default: begin
                state_next = IDLE;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state     <= IDLE;
            hold      <= 1'b1;
            s_awready <= 1'b0;
            m_awvalid <= 1'b0;
            count     <= '0;
        end else begin
            state     <= state_next;
            hold      <= hold_next;
            s_awready <= s_awready_next;
            m_awvalid <= m_awvalid_next;
            count     <= count_next;
        end

        if (aw_take) begin
            m_aw <= s_aw;
        end
    end

    // Outbound address must not change while the RAM stalls it
    a_m_aw_stable: assert property (
        @(posedge clk) disable iff (rst)
        m_awvalid && !m_awready |=> m_awvalid && $stable(m_aw)
    );

endmodule

// File: hw/axi_fifo_wr/axi_w_fifo.sv
// ----------------------------------------------------------------------
// Write data FIFO
// Wrap-bit pointers, registered memory read and an output register
// ----------------------------------------------------------------------

`timescale 1ns/1ps

module axi_w_fifo (
    input  logic                clk,
    input  logic                rst,
    input  axi_wr_pkg::w_beat_t s_w,
    input  logic                s_wvalid,
    output logic                s_wready,
    input  logic                hold,
    output axi_wr_pkg::w_beat_t m_w,
    output logic                m_wvalid,
    input  logic                m_wready
);

    axi_wr_pkg::w_beat_t   mem [axi_wr_pkg::FIFO_DEPTH];
    axi_wr_pkg::w_beat_t   rd_data;
    logic                  rd_valid;
    axi_wr_pkg::fifo_ptr_t wr_ptr;
    axi_wr_pkg::fifo_ptr_t rd_ptr;
    logic                  full;
    logic                  empty;
    logic                  write;
    logic                  read;
    logic                  out_load;

    // Same slot, opposite lap
    assign full = (wr_ptr[axi_wr_pkg::FIFO_AW] != rd_ptr[axi_wr_pkg::FIFO_AW]) &&
                  (wr_ptr[axi_wr_pkg::FIFO_AW-1:0] == rd_ptr[axi_wr_pkg::FIFO_AW-1:0]);
    assign empty = wr_ptr == rd_ptr;

    // Nothing enters while the address block holds the burst back
    assign s_wready = !full && !hold;
    assign write    = s_wvalid && s_wready;

    // Output register free or being emptied this cycle
    assign out_load = m_wready || !m_wvalid;
    assign read     = !empty && (out_load || !rd_valid);

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr <= '0;
        end else if (write) begin
            wr_ptr <= wr_ptr + 1'b1;
        end

        if (write) begin
            mem[wr_ptr[axi_wr_pkg::FIFO_AW-1:0]] <= s_w;
        end
    end

    // Memory read stage
    always_ff @(posedge clk) begin
        if (rst) begin
            rd_ptr   <= '0;
            rd_valid <= 1'b0;
        end else begin
            if (read) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            if (out_load || !rd_valid) begin
                rd_valid <= !empty;
            end
        end

        if (read) begin
            rd_data <= mem[rd_ptr[axi_wr_pkg::FIFO_AW-1:0]];
        end
    end

    // Output register holds its beat under back-pressure
    always_ff @(posedge clk) begin
        if (rst) begin
            m_wvalid <= 1'b0;
        end else if (out_load) begin
            m_wvalid <= rd_valid;
        end

        if (out_load) begin
            m_w <= rd_data;
        end
    end

    // Pointers a whole depth apart block any further write
    a_no_overflow: assert property (
        @(posedge clk) disable iff (rst)
        axi_wr_pkg::fifo_ptr_t'(wr_ptr - rd_ptr) ==
            axi_wr_pkg::fifo_ptr_t'(axi_wr_pkg::FIFO_DEPTH)
        |=> wr_ptr == $past(wr_ptr)
    );

endmodule

// File: hw/axi_ram_wr.sv
// ----------------------------------------------------------------------
// AXI4 burst write slave over a word RAM
// INCR bursts with byte strobes, B response and a host read port
// ----------------------------------------------------------------------

`timescale 1ns/1ps

module axi_ram_wr (
    input  logic                  clk,
    input  logic                  rst,
    input  axi_wr_pkg::aw_beat_t  m_aw,
    input  logic                  m_awvalid,
    output logic                  m_awready,
    input  axi_wr_pkg::w_beat_t   m_w,
    input  logic                  m_wvalid,
    output logic                  m_wready,
    output axi_wr_pkg::b_beat_t   b,
    output logic                  bvalid,
    input  logic                  bready,
    input  axi_wr_pkg::ram_addr_t rd_addr,
    output axi_wr_pkg::axi_data_t rd_data
);

    typedef enum logic [1:0] {
        IDLE,
        DATA,
        RESP
    } state_t;

    state_t                state;
    axi_wr_pkg::axi_data_t mem [axi_wr_pkg::RAM_WORDS];
    axi_wr_pkg::axi_addr_t word_idx;
    axi_wr_pkg::axi_id_t   id_reg;
    logic                  size_ok;
    logic                  err;
    logic                  in_range;
    logic                  aw_take;
    logic                  w_take;
    logic                  wr_en;

    assign m_awready = state == IDLE;
    assign m_wready  = state == DATA;
    assign bvalid    = state == RESP;

    assign aw_take  = m_awvalid && m_awready;
    assign w_take   = m_wvalid && m_wready;
    assign in_range = word_idx < axi_wr_pkg::axi_addr_t'(axi_wr_pkg::RAM_WORDS);
    assign wr_en    = w_take && in_range && size_ok;

    assign b.id   = id_reg;
    assign b.resp = (err || !size_ok) ? axi_wr_pkg::RESP_SLVERR : axi_wr_pkg::RESP_OKAY;

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= IDLE;
            err   <= 1'b0;
        end else begin
            case (state)
                IDLE: begin
                    if (aw_take) begin
                        state <= DATA;
                        err   <= 1'b0;
                    end
                end
                DATA: begin
                    if (w_take) begin
                        // Any beat past the end spoils the whole burst
                        if (!in_range) begin
                            err <= 1'b1;
                        end
                        if (m_w.last) begin
                            state <= RESP;
                        end
                    end
                end
                RESP: begin
                    if (bready) begin
                        state <= IDLE;
                    end
                end
                default: begin
                    state <= IDLE;
                end
            endcase
        end
    end

    // Burst context, INCR word stepping
    always_ff @(posedge clk) begin
        if (aw_take) begin
            id_reg   <= m_aw.id;
            word_idx <= {2'b00, m_aw.addr[15:2]};
            // Only full 4-byte beats are honoured
            size_ok  <= m_aw.size == 3'd2;
        end else if (w_take) begin
            word_idx <= word_idx + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (wr_en) begin
            for (int i = 0; i < $bits(axi_wr_pkg::axi_strb_t); i++) begin
                if (m_w.strb[i]) begin
                    mem[axi_wr_pkg::ram_addr_t'(word_idx)][8*i +: 8] <= m_w.data[8*i +: 8];
                end
            end
        end

        // Host read port
        rd_data <= mem[rd_addr];
    end

    a_b_stable: assert property (
        @(posedge clk) disable iff (rst)
        bvalid && !bready |=> bvalid && $stable(b)
    );

endmodule

// File: hw/axi_wr_buffer_top.sv
// ----------------------------------------------------------------------
// Buffered AXI4 write path
// Address hold, write data FIFO and burst write RAM
// ----------------------------------------------------------------------

`timescale 1ns/1ps

module axi_wr_buffer_top (
    input  logic                  clk,
    input  logic                  rst,
    input  axi_wr_pkg::aw_beat_t  s_aw,
    input  logic                  s_awvalid,
    output logic                  s_awready,
    input  axi_wr_pkg::w_beat_t   s_w,
    input  logic                  s_wvalid,
    output logic                  s_wready,
    output axi_wr_pkg::b_beat_t   s_b,
    output logic                  s_bvalid,
    input  logic                  s_bready,
    input  axi_wr_pkg::ram_addr_t rd_addr,
    output axi_wr_pkg::axi_data_t rd_data
);

    axi_wr_pkg::aw_beat_t m_aw;
    logic                 m_awvalid;
    logic                 m_awready;
    axi_wr_pkg::w_beat_t  m_w;
    logic                 m_wvalid;
    logic                 m_wready;
    logic                 hold;

    // Watches accepted W beats to know when a burst is buffered
    axi_aw_hold axi_aw_hold_i (
        .clk       (clk),
        .rst       (rst),
        .s_aw      (s_aw),
        .s_awvalid (s_awvalid),
        .s_awready (s_awready),
        .s_wvalid  (s_wvalid),
        .s_wready  (s_wready),
        .hold      (hold),
        .m_aw      (m_aw),
        .m_awvalid (m_awvalid),
        .m_awready (m_awready)
    );

    axi_w_fifo axi_w_fifo_i (
        .clk      (clk),
        .rst      (rst),
        .s_w      (s_w),
        .s_wvalid (s_wvalid),
        .s_wready (s_wready),
        .hold     (hold),
        .m_w      (m_w),
        .m_wvalid (m_wvalid),
        .m_wready (m_wready)
    );

    // B channel goes straight out to the master
    axi_ram_wr axi_ram_wr_i (
        .clk       (clk),
        .rst       (rst),
        .m_aw      (m_aw),
        .m_awvalid (m_awvalid),
        .m_awready (m_awready),
        .m_w       (m_w),
        .m_wvalid  (m_wvalid),
        .m_wready  (m_wready),
        .b         (s_b),
        .bvalid    (s_bvalid),
        .bready    (s_bready),
        .rd_addr   (rd_addr),
        .rd_data   (rd_data)
    );

endmodule

// File: run.sh
#!/bin/sh
# Build the testbench with Verilator, run it and look for the pass message

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f flist.f \
    --top-module axi_wr_buffer_tb -o axi_wr_buffer_sim || { echo "Build failed"; exit 1; }

out=$(./obj_dir/axi_wr_buffer_sim 2>&1)
echo "$out"
echo "$out" | grep -qx "No errors" && echo "Simulation passed" || { echo "Simulation failed"; exit 1; }

// File: verif/axi_wr_buffer_tb.sv
// ----------------------------------------------------------------------
// Testbench for the buffered AXI4 write path
// Burst table, scoreboard RAM model, host read-back and watchdog
// ----------------------------------------------------------------------

`timescale 1ns/1ps

module axi_wr_buffer_tb;

    localparam int NUM_BURSTS = 7;

    // One row of the stimulus table
    typedef struct packed {
        axi_wr_pkg::axi_id_t   id;
        axi_wr_pkg::axi_addr_t addr;
        axi_wr_pkg::axi_len_t  len;
        axi_wr_pkg::axi_data_t data_seed;
        axi_wr_pkg::axi_strb_t strb;
        axi_wr_pkg::axi_resp_t resp;
        logic                  overlap;
        logic                  b_stall;
    } burst_t;

    logic                  clk;
    logic                  rst;
    axi_wr_pkg::aw_beat_t  s_aw;
    logic                  s_awvalid;
    logic                  s_awready;
    axi_wr_pkg::w_beat_t   s_w;
    logic                  s_wvalid;
    logic                  s_wready;
    axi_wr_pkg::b_beat_t   s_b;
    logic                  s_bvalid;
    logic                  s_bready;
    axi_wr_pkg::ram_addr_t rd_addr;
    axi_wr_pkg::axi_data_t rd_data;

    burst_t                tbl [NUM_BURSTS];
    axi_wr_pkg::axi_data_t wdata [256];
    axi_wr_pkg::axi_strb_t wstrb [256];
    axi_wr_pkg::axi_data_t model_mem [axi_wr_pkg::RAM_WORDS];
    axi_wr_pkg::axi_strb_t known [axi_wr_pkg::RAM_WORDS];
    int                    seed;
    logic                  table_loaded;
    logic                  aw_early_taken;

    tb_clk_gen tb_clk_gen_i (
        .clk (clk),
        .rst (rst)
    );

    axi_wr_buffer_top axi_wr_buffer_top_i (
        .clk       (clk),
        .rst       (rst),
        .s_aw      (s_aw),
        .s_awvalid (s_awvalid),
        .s_awready (s_awready),
        .s_w       (s_w),
        .s_wvalid  (s_wvalid),
        .s_wready  (s_wready),
        .s_b       (s_b),
        .s_bvalid  (s_bvalid),
        .s_bready  (s_bready),
        .rd_addr   (rd_addr),
        .rd_data   (rd_data)
    );

    task automatic stop_run();
        $display("Errors found");
        $fatal(1, "Simulation stopped");
    endtask

    task automatic check_value(input string name, input logic [31:0] exp,
                               input logic [31:0] got);
        assert (got == exp) else begin
            $display("CHECK FAILED at %0t ns: %s expected %h got %h", $time, name, exp, got);
            stop_run();
        end
    endtask

    function automatic axi_wr_pkg::w_beat_t make_w(input int n, input int k);
        axi_wr_pkg::w_beat_t w;
        w.data = wdata[k];
        w.strb = wstrb[k];
        w.last = k == int'(tbl[n].len);
        return w;
    endfunction

    // Beat data, scoreboard update and expected response of one burst
    function automatic axi_wr_pkg::axi_resp_t prepare_burst(input int n);
        axi_wr_pkg::axi_resp_t resp;
        axi_wr_pkg::axi_strb_t strb;
        int                    idx;
        resp = axi_wr_pkg::RESP_OKAY;
        strb = tbl[n].strb;
        for (int k = 0; k <= int'(tbl[n].len); k++) begin
            wdata[k] = $random(seed) ^ tbl[n].data_seed;
            wstrb[k] = strb;
            strb = {strb[2:0], strb[3]};
            // INCR steps one word per beat
            idx = int'(tbl[n].addr[15:2]) + k;
            if (idx >= axi_wr_pkg::RAM_WORDS) begin
                resp = axi_wr_pkg::RESP_SLVERR;
            end else begin
                for (int i = 0; i < 4; i++) begin
                    if (wstrb[k][i]) begin
                        model_mem[idx][8*i +: 8] = wdata[k][8*i +: 8];
                        known[idx][i] = 1'b1;
                    end
                end
            end
        end
        return resp;
    endfunction

    // AW and W beats of one burst, next AW shown early on overlap rows
    task automatic send_burst(input int n);
        int   beat;
        int   held;
        logic aw_done;
        logic next_done;
        logic early;
        beat = 0;
        held = 0;
        early = 1'b0;
        aw_done = aw_early_taken;
        next_done = !tbl[n].overlap;
        aw_early_taken = 1'b0;
        if (!aw_done) begin
            s_aw      <= '{tbl[n].id, tbl[n].addr, tbl[n].len, 3'd2};
            s_awvalid <= 1'b1;
        end
        s_w      <= make_w(n, 0);
        s_wvalid <= 1'b1;
        while (!(aw_done && next_done && beat > int'(tbl[n].len))) begin
            @(posedge clk);
            // Second address waiting while beats are still outstanding
            if (aw_done && !next_done && beat <= int'(tbl[n].len)) begin
                held++;
                early = early || s_awready;
            end
            if (s_awvalid && s_awready) begin
                if (!aw_done) begin
                    aw_done = 1'b1;
                    if (tbl[n].overlap) begin
                        s_aw <= '{tbl[n+1].id, tbl[n+1].addr, tbl[n+1].len, 3'd2};
                    end else begin
                        s_awvalid <= 1'b0;
                    end
                end else begin
                    next_done = 1'b1;
                    aw_early_taken = 1'b1;
                    s_awvalid <= 1'b0;
                end
            end
            if (s_wvalid && s_wready) begin
                beat++;
                if (beat > int'(tbl[n].len)) begin
                    s_wvalid <= 1'b0;
                end else begin
                    s_w <= make_w(n, beat);
                end
            end
        end
        assert (!early && (held > 0 || !tbl[n].overlap)) else begin
            $display("Address hold broken on burst %0d: early accept %0b, %0d held cycles",
                     n, early, held);
            stop_run();
        end
    endtask

    task automatic check_response(input int n, input axi_wr_pkg::axi_resp_t exp_resp);
        int                  stall;
        axi_wr_pkg::b_beat_t first;
        stall = 0;
        if (tbl[n].b_stall) begin
            stall = 1 + int'($unsigned($random(seed)) % 8);
        end
        s_bready <= stall == 0;
        do begin
            @(posedge clk);
        end while (!s_bvalid);
        first = s_b;
        // Response has to sit still while the master stalls
        for (int c = 0; c < stall; c++) begin
            if (c == stall - 1) begin
                s_bready <= 1'b1;
            end
            @(posedge clk);
            check_value("s_bvalid", 32'd1, 32'(s_bvalid));
            check_value("s_b", 32'(first), 32'(s_b));
        end
        s_bready <= 1'b0;
        check_value("s_b.id", 32'(tbl[n].id), 32'(first.id));
        check_value("s_b.resp", 32'(exp_resp), 32'(first.resp));
    endtask

    task automatic read_back();
        logic [31:0] mask;
        for (int w = 0; w < axi_wr_pkg::RAM_WORDS; w++) begin
            rd_addr <= axi_wr_pkg::ram_addr_t'(w);
            @(posedge clk);
            @(posedge clk);
            // Bytes never written are left out
            for (int i = 0; i < 4; i++) begin
                mask[8*i +: 8] = {8{known[w][i]}};
            end
            check_value($sformatf("rd_data[%0d]", w), model_mem[w] & mask, rd_data & mask);
        end
    endtask

    initial begin
        axi_wr_pkg::axi_resp_t exp_resp;
        seed = 98;
        aw_early_taken = 1'b0;
        // id, addr, len, data seed, strobes, resp, next AW early, B stall
        tbl[0] = '{4'h1, 16'h0004, 8'd0, 32'h00000000, 4'hf, axi_wr_pkg::RESP_OKAY, 1'b0, 1'b0};
        tbl[1] = '{4'h2, 16'h0100, 8'd31, 32'h11111111, 4'hf, axi_wr_pkg::RESP_OKAY, 1'b0, 1'b1};
        tbl[2] = '{4'h3, 16'h0120, 8'd7, 32'h22222222, 4'h5, axi_wr_pkg::RESP_OKAY, 1'b0, 1'b0};
        tbl[3] = '{4'h4, 16'h0200, 8'd3, 32'h33333333, 4'hf, axi_wr_pkg::RESP_OKAY, 1'b1, 1'b0};
        tbl[4] = '{4'h5, 16'h0240, 8'd5, 32'h44444444, 4'hc, axi_wr_pkg::RESP_OKAY, 1'b0, 1'b1};
        tbl[5] = '{4'h6, 16'h03f8, 8'd3, 32'hbeef0000, 4'hf, axi_wr_pkg::RESP_SLVERR, 1'b0, 1'b0};
        tbl[6] = '{4'h7, 16'h0050, 8'd2, 32'h0000cafe, 4'h3, axi_wr_pkg::RESP_OKAY, 1'b0, 1'b1};
        table_loaded = 1'b1;
        for (int w = 0; w < axi_wr_pkg::RAM_WORDS; w++) begin
            known[w] = '0;
        end
        s_aw      <= '0;
        s_awvalid <= 1'b0;
        s_w       <= '0;
        s_wvalid  <= 1'b0;
        s_bready  <= 1'b0;
        rd_addr   <= '0;
        do begin
            @(posedge clk);
        end while (rst);

        for (int n = 0; n < NUM_BURSTS; n++) begin
            exp_resp = prepare_burst(n);
            assert (exp_resp == tbl[n].resp) else begin
                $display("Table row %0d expects a response the scoreboard rules deny", n);
                stop_run();
            end
            send_burst(n);
            check_response(n, exp_resp);
            read_back();
        end
        $display("No errors");
        $finish;
    end

    // Budget of 20 cycles per beat plus read-back time per burst
    initial begin : watchdog
        int limit;
        wait (table_loaded === 1'b1);
        limit = 20;
        for (int n = 0; n < NUM_BURSTS; n++) begin
            limit += (int'(tbl[n].len) + 1) * 20 + 2 * axi_wr_pkg::RAM_WORDS + 100;
        end
        repeat (limit) @(posedge clk);
        $display("Timeout: the run did not finish within %0d clock cycles", limit);
        stop_run();
    end

endmodule

// File: verif/tb_clk_gen.sv
// ----------------------------------------------------------------------
// Testbench clock and reset generator
// 40 ns clock, reset high for the first 4 rising edges
// ----------------------------------------------------------------------

`timescale 1ns/1ps

module tb_clk_gen (
    output logic clk,
    output logic rst
);

    localparam int HALF_PERIOD = 20;

    initial begin
        clk = 1'b0;
        forever begin
            #HALF_PERIOD clk = ~clk;
        end
    end

    initial begin
        rst = 1'b1;
        repeat (4) @(posedge clk);
        rst <= 1'b0;
    end

endmodule
